//--- hdl/dma_hub_pkg.sv
// Widths, opcodes and beat layouts shared by every DMA hub module through a wildcard import
`default_nettype none

package dma_hub_pkg;

    // -------------------------------------------------
    // Widths
    // -------------------------------------------------
    localparam int BEAT_W    = 64;              // Stream beat
    localparam int DATA_W    = 32;              // Register word
    localparam int TAG_W     = 8;               // Request tag
    localparam int REG_SEL_W = 2;               // Register index in a channel
    localparam int CHAN_W    = 4;               // Up to 16 channels
    localparam int BAR_W     = 3;
    localparam int CPL_ID_W  = 16;              // Completer id in the header

    // Register map of one channel
    localparam logic [REG_SEL_W-1:0] REG_SCRATCH  = 2'd0;
    localparam logic [REG_SEL_W-1:0] REG_CONTROL  = 2'd1;  // Bit 0 irq enable
    localparam logic [REG_SEL_W-1:0] REG_DOORBELL = 2'd2;
    localparam logic [REG_SEL_W-1:0] REG_STATUS   = 2'd3;  // W1C pending and overflow

    typedef enum logic [1:0] {
        OP_MEM_WR = 2'd0,
        OP_MEM_RD = 2'd1,
        OP_CPL    = 2'd2,
        OP_NONE   = 2'd3
    } tlp_op_t;

    // -------------------------------------------------
    // Inbound beats
    // -------------------------------------------------
    typedef struct packed {
        tlp_op_t                    op;
        logic [BAR_W-1:0]           bar;
        logic [TAG_W-1:0]           tag;
        logic [50:0]                rsvd;           // Zero
    } req_hdr_t;

    typedef struct packed {
        logic [CHAN_W-1:0]          chan;
        logic [REG_SEL_W-1:0]       reg_sel;
        logic [25:0]                rsvd;           // Zero
        logic [DATA_W-1:0]          data;
    } req_body_t;

    // Routed request, shared by all channels
    typedef struct packed {
        tlp_op_t                    op;
        logic [TAG_W-1:0]           tag;
        logic [REG_SEL_W-1:0]       reg_sel;
        logic [DATA_W-1:0]          data;
    } chan_req_t;

    // -------------------------------------------------
    // Completions
    // -------------------------------------------------
    typedef struct packed {
        logic [TAG_W-1:0]           tag;
        logic [DATA_W-1:0]          data;
    } cpl_entry_t;

    typedef struct packed {
        tlp_op_t                    op;             // Always OP_CPL
        logic [CPL_ID_W-1:0]        completer_id;
        logic [TAG_W-1:0]           tag;
        logic [CHAN_W-1:0]          chan;
        logic [33:0]                pad;
    } cpl_hdr_t;

endpackage

`default_nettype wire

//--- hdl/rx_request_decoder.sv
// Frames two-beat inbound requests, filters BAR, opcode and channel, and routes them
`default_nettype none

module rx_request_decoder
    import dma_hub_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int BAR_INDEX    = 2
) (
    input  logic                    pcie_clk,
    input  logic                    reset,
    input  logic [BEAT_W-1:0]       rx_data,
    input  logic                    rx_sof,
    input  logic                    rx_eof,
    input  logic                    rx_valid,
    output chan_req_t               req,
    output logic [NUM_CHANNELS-1:0] req_sel
);

    typedef enum logic {
        DEC_HEADER,
        DEC_BODY
    } dec_state_t;

    dec_state_t                 state_q;
    req_hdr_t                   hdr_q;          // Latched header beat
    req_hdr_t                   rx_hdr;
    req_body_t                  rx_body;
    logic                       hdr_take;
    logic                       body_beat;
    logic                       hdr_ok;
    logic                       chan_ok;
    logic                       issue;
    logic [NUM_CHANNELS-1:0]    sel_d;

    assign rx_hdr  = req_hdr_t'(rx_data);
    assign rx_body = req_body_t'(rx_data);

    // -------------------------------------------------
    // Framing checks
    // -------------------------------------------------
    assign hdr_take  = rx_valid && rx_sof && !rx_eof;   // Restarts framing anywhere
    assign body_beat = rx_valid && !rx_sof && (state_q == DEC_BODY);

    assign hdr_ok  = ((hdr_q.op == OP_MEM_WR) || (hdr_q.op == OP_MEM_RD)) &&
                     (hdr_q.bar == BAR_W'(BAR_INDEX));
    assign chan_ok = int'(rx_body.chan) < NUM_CHANNELS;
    assign issue   = body_beat && rx_eof && hdr_ok && chan_ok;

    always_comb begin
        sel_d = '0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            sel_d[i] = issue && (int'(rx_body.chan) == i);
        end
    end

    // -------------------------------------------------
    // State and strobes
    // -------------------------------------------------
    always_ff @(posedge pcie_clk) begin
        if (reset) begin
            state_q <= DEC_HEADER;
            req_sel <= '0;
        end else begin
            req_sel <= sel_d;                   // One-cycle pulse
            if (hdr_take) begin
                state_q <= DEC_BODY;
            end else if (rx_valid && (state_q == DEC_BODY)) begin
                state_q <= DEC_HEADER;          // Body consumed or dropped
            end
        end
    end

    // Payload registers
    always_ff @(posedge pcie_clk) begin
        if (hdr_take) begin
            hdr_q <= rx_hdr;
        end
        if (issue) begin
            req.op      <= hdr_q.op;
            req.tag     <= hdr_q.tag;
            req.reg_sel <= rx_body.reg_sel;
            req.data    <= rx_body.data;
        end
    end

endmodule

`default_nettype wire

//--- hdl/bar_register_channel.sv
// One BAR-mapped register channel with its read completion queue and interrupt flag
`default_nettype none

module bar_register_channel
    import dma_hub_pkg::*;
#(
    parameter int CPL_DEPTH = 4
) (
    input  logic        pcie_clk,
    input  logic        reset,
    input  chan_req_t   req,
    input  logic        req_sel,
    output logic        cpl_valid,
    output cpl_entry_t  cpl_head,
    input  logic        cpl_pop,
    output logic        irq_pending
);

    localparam int PTR_W = (CPL_DEPTH > 1) ? $clog2(CPL_DEPTH) : 1;
    localparam int CNT_W = $clog2(CPL_DEPTH + 1);

    // -------------------------------------------------
    // Register file
    // -------------------------------------------------
    logic [DATA_W-1:0]  scratch_q;
    logic               irq_en_q;           // REG_CONTROL bit 0
    logic [DATA_W-1:0]  doorbell_q;         // Doorbell write count
    logic               pending_q;
    logic               overflow_q;         // Read lost on a full queue
    logic [DATA_W-1:0]  rd_value;

    // Completion queue
    cpl_entry_t         queue_mem [CPL_DEPTH];
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_q;
    logic [CNT_W-1:0]   count_q;
    logic               full;
    logic               wr_en;
    logic               rd_en;
    logic               push;
    logic               pop;

    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(CPL_DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign wr_en = req_sel && (req.op == OP_MEM_WR);
    assign rd_en = req_sel && (req.op == OP_MEM_RD);
    assign full  = (count_q == CNT_W'(CPL_DEPTH));
    assign push  = rd_en && !full;
    assign pop   = cpl_pop && cpl_valid;

    always_comb begin
        case (req.reg_sel)
            REG_SCRATCH:  rd_value = scratch_q;
            REG_CONTROL:  rd_value = {{(DATA_W-1){1'b0}}, irq_en_q};
            REG_DOORBELL: rd_value = doorbell_q;
            REG_STATUS:   rd_value = {{(DATA_W-2){1'b0}}, overflow_q, pending_q};
            default:      rd_value = '0;
        endcase
    end

    always_ff @(posedge pcie_clk) begin
        if (reset) begin
            scratch_q  <= '0;
            irq_en_q   <= 1'b0;
            doorbell_q <= '0;
            pending_q  <= 1'b0;
            overflow_q <= 1'b0;
        end else begin
            if (wr_en) begin
                case (req.reg_sel)
                    REG_SCRATCH:  scratch_q <= req.data;
                    REG_CONTROL:  irq_en_q  <= req.data[0];
                    REG_DOORBELL: begin
                        doorbell_q <= doorbell_q + 1'b1;
                        if (irq_en_q) begin
                            pending_q <= 1'b1;      // Ring only when enabled
                        end
                    end
                    REG_STATUS: begin
                        if (req.data[0]) begin
                            pending_q <= 1'b0;
                        end
                        if (req.data[1]) begin
                            overflow_q <= 1'b0;
                        end
                    end
                    default: ;
                endcase
            end
            if (rd_en && full) begin
                overflow_q <= 1'b1;                 // Read dropped
            end
        end
    end

    // -------------------------------------------------
    // Completion queue
    // -------------------------------------------------
    always_ff @(posedge pcie_clk) begin
        if (reset) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push) begin
                wr_ptr_q <= ptr_next(wr_ptr_q);
            end
            if (pop) begin
                rd_ptr_q <= ptr_next(rd_ptr_q);
            end
            case ({push, pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (push) begin
            queue_mem[wr_ptr_q] <= '{tag: req.tag, data: rd_value};
        end
    end

    assign cpl_valid   = (count_q != '0);
    assign cpl_head    = queue_mem[rd_ptr_q];   // Oldest read first
    assign irq_pending = pending_q;

endmodule

`default_nettype wire

//--- hdl/host_return_path.sv
// Round-robin completion arbiter and outbound two-beat framer with the merged interrupt
`default_nettype none

module host_return_path
    import dma_hub_pkg::*;
#(
    parameter int NUM_CHANNELS = 4
) (
    input  logic                                pcie_clk,
    input  logic                                reset,
    input  logic [CPL_ID_W-1:0]                 completer_id,
    input  logic [NUM_CHANNELS-1:0]             cpl_valid,
    input  cpl_entry_t [NUM_CHANNELS-1:0]       cpl_head,
    output logic [NUM_CHANNELS-1:0]             cpl_pop,
    input  logic [NUM_CHANNELS-1:0]             irq_pending,
    output logic [BEAT_W-1:0]                   tx_data,
    output logic                                tx_sof,
    output logic                                tx_eof,
    output logic                                tx_valid,
    input  logic                                tx_ready,
    output logic                                irq
);

    localparam int IDX_W = (NUM_CHANNELS > 1) ? $clog2(NUM_CHANNELS) : 1;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_HDR,
        TX_DATA
    } tx_state_t;

    tx_state_t          state_q;
    logic [IDX_W-1:0]   last_q;             // Last channel served
    logic [IDX_W-1:0]   grant_idx;
    logic               grant_found;
    logic               grant;
    cpl_entry_t         entry_q;            // Popped completion
    logic [CHAN_W-1:0]  chan_q;
    cpl_hdr_t           hdr;

    // -------------------------------------------------
    // Round-robin pick
    // -------------------------------------------------
    always_comb begin
        int idx;
        grant_idx   = last_q;
        grant_found = 1'b0;
        for (int k = 1; k <= NUM_CHANNELS; k++) begin
            idx = (int'(last_q) + k) % NUM_CHANNELS;
            if (!grant_found && cpl_valid[idx]) begin
                grant_found = 1'b1;
                grant_idx   = IDX_W'(idx);
            end
        end
    end

    // Hold grants while the link is stalled
    assign grant = (state_q == TX_IDLE) && tx_ready && grant_found;

    always_comb begin
        cpl_pop = '0;
        if (grant) begin
            cpl_pop[grant_idx] = 1'b1;
        end
    end

    // -------------------------------------------------
    // Framer
    // -------------------------------------------------
    always_ff @(posedge pcie_clk) begin
        if (reset) begin
            state_q <= TX_IDLE;
            last_q  <= IDX_W'(NUM_CHANNELS - 1);    // Channel 0 goes first
            irq     <= 1'b0;
        end else begin
            irq <= |irq_pending;
            case (state_q)
                TX_IDLE: begin
                    if (grant) begin
                        state_q <= TX_HDR;
                        last_q  <= grant_idx;
                    end
                end
                TX_HDR:  if (tx_ready) state_q <= TX_DATA;
                TX_DATA: if (tx_ready) state_q <= TX_IDLE;
                default: state_q <= TX_IDLE;
            endcase
        end
    end

    always_ff @(posedge pcie_clk) begin
        if (grant) begin
            entry_q <= cpl_head[grant_idx];
            chan_q  <= CHAN_W'(grant_idx);
        end
    end

    always_comb begin
        hdr.op           = OP_CPL;
        hdr.completer_id = completer_id;
        hdr.tag          = entry_q.tag;
        hdr.chan         = chan_q;
        hdr.pad          = '0;
        case (state_q)
            TX_HDR:  tx_data = hdr;
            TX_DATA: tx_data = {{(BEAT_W-DATA_W){1'b0}}, entry_q.data};
            default: tx_data = '0;
        endcase
    end

    assign tx_valid = (state_q != TX_IDLE);
    assign tx_sof   = (state_q == TX_HDR);
    assign tx_eof   = (state_q == TX_DATA);

endmodule

`default_nettype wire

//--- hdl/dma_hub_top.sv
// DMA hub top level that ties the request decoder, register channels and return path together
`default_nettype none

module dma_hub_top
    import dma_hub_pkg::*;
#(
    parameter int NUM_CHANNELS = 4,
    parameter int BAR_INDEX    = 2,
    parameter int CPL_DEPTH    = 4
) (
    input  logic                    pcie_clk,
    input  logic                    reset,
    // Inbound stream
    input  logic [BEAT_W-1:0]       rx_data,
    input  logic                    rx_sof,
    input  logic                    rx_eof,
    input  logic                    rx_valid,
    input  logic [CPL_ID_W-1:0]     completer_id,
    // Outbound stream
    output logic [BEAT_W-1:0]       tx_data,
    output logic                    tx_sof,
    output logic                    tx_eof,
    output logic                    tx_valid,
    input  logic                    tx_ready,
    output logic                    irq
);

    // -------------------------------------------------
    // Internal nets
    // -------------------------------------------------
    chan_req_t                          req;            // Shared by all channels
    logic [NUM_CHANNELS-1:0]            req_sel;
    logic [NUM_CHANNELS-1:0]            cpl_valid;
    cpl_entry_t [NUM_CHANNELS-1:0]      cpl_head;
    logic [NUM_CHANNELS-1:0]            cpl_pop;
    logic [NUM_CHANNELS-1:0]            irq_pending;

    rx_request_decoder #(
        .NUM_CHANNELS   (NUM_CHANNELS),
        .BAR_INDEX      (BAR_INDEX)
    ) rx_request_decoder_i (
        .pcie_clk       (pcie_clk),
        .reset          (reset),
        .rx_data        (rx_data),
        .rx_sof         (rx_sof),
        .rx_eof         (rx_eof),
        .rx_valid       (rx_valid),
        .req            (req),
        .req_sel        (req_sel)
    );

    // -------------------------------------------------
    // Register channels
    // -------------------------------------------------
    for (genvar ch = 0; ch < NUM_CHANNELS; ch++) begin : g_chan
        bar_register_channel #(
            .CPL_DEPTH      (CPL_DEPTH)
        ) bar_register_channel_i (
            .pcie_clk       (pcie_clk),
            .reset          (reset),
            .req            (req),
            .req_sel        (req_sel[ch]),
            .cpl_valid      (cpl_valid[ch]),
            .cpl_head       (cpl_head[ch]),
            .cpl_pop        (cpl_pop[ch]),
            .irq_pending    (irq_pending[ch])
        );
    end

    host_return_path #(
        .NUM_CHANNELS   (NUM_CHANNELS)
    ) host_return_path_i (
        .pcie_clk       (pcie_clk),
        .reset          (reset),
        .completer_id   (completer_id),
        .cpl_valid      (cpl_valid),
        .cpl_head       (cpl_head),
        .cpl_pop        (cpl_pop),
        .irq_pending    (irq_pending),
        .tx_data        (tx_data),
        .tx_sof         (tx_sof),
        .tx_eof         (tx_eof),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .irq            (irq)           // Merged channel interrupts
    );

endmodule

`default_nettype wire

//--- verification/dma_hub_sva.sv
// Assertions on the outbound completion stream that are bound into the DMA hub top level
`default_nettype none

module dma_hub_sva
    import dma_hub_pkg::*;
(
    input  logic                pcie_clk,
    input  logic                reset,
    input  logic [BEAT_W-1:0]   tx_data,
    input  logic                tx_sof,
    input  logic                tx_eof,
    input  logic                tx_valid,
    input  logic                tx_ready
);

    // -------------------------------------------------
    // Outbound framing
    // -------------------------------------------------
    hold_while_stalled: assert property (
        @(posedge pcie_clk) disable iff (reset)
        (tx_valid && !tx_ready) |=>
            (tx_valid && $stable(tx_data) && $stable(tx_sof) && $stable(tx_eof))
    ) else $error("Outbound beat changed while tx_ready was low");

    sof_eof_exclusive: assert property (
        @(posedge pcie_clk) disable iff (reset)
        !(tx_sof && tx_eof)
    ) else $error("tx_sof and tx_eof high in the same beat");

    // Header beat is always followed by the data beat
    data_after_header: assert property (
        @(posedge pcie_clk) disable iff (reset)
        (tx_valid && tx_ready && tx_sof) |=> (tx_valid && tx_eof && !tx_sof)
    ) else $error("Accepted header beat not followed by a data beat");

endmodule

bind dma_hub_top dma_hub_sva dma_hub_sva_i (
    .pcie_clk   (pcie_clk),
    .reset      (reset),
    .tx_data    (tx_data),
    .tx_sof     (tx_sof),
    .tx_eof     (tx_eof),
    .tx_valid   (tx_valid),
    .tx_ready   (tx_ready)
);

`default_nettype wire

//--- verification/dma_hub_tb.sv
// Testbench that drives DMA hub requests and checks completions and irq against a model
`default_nettype none

module dma_hub_tb
    import dma_hub_pkg::*;
();

    localparam int          NUM_CHANNELS    = 4;
    localparam int          BAR_INDEX       = 2;
    localparam int          CPL_DEPTH       = 4;
    localparam int          CLK_PERIOD      = 10;
    localparam int          RESET_CYCLES    = 8;
    localparam int          IRQ_LATENCY     = 3;    // Body beat to irq update
    localparam int          RAND_READS      = 48;
    localparam logic [15:0] COMPLETER_ID    = 16'h01a5;
    // Total request count that sizes the watchdog
    localparam int          TOTAL_REQS      = 2 * NUM_CHANNELS + 6 + 11 + RAND_READS +
                                              CPL_DEPTH + 5;
    localparam int          WATCHDOG_CYCLES = TOTAL_REQS * 40 + RESET_CYCLES + 200;

    typedef enum logic [1:0] {
        READY_HIGH,
        READY_RANDOM,
        READY_LOW
    } ready_mode_t;

    // Expected register state of one channel
    typedef struct packed {
        logic [DATA_W-1:0]  scratch;
        logic               irq_en;
        logic [DATA_W-1:0]  doorbell;
        logic               pending;
        logic               overflow;
    } chan_model_t;

    logic                   pcie_clk;
    logic                   reset;
    logic [BEAT_W-1:0]      rx_data;
    logic                   rx_sof;
    logic                   rx_eof;
    logic                   rx_valid;
    logic [CPL_ID_W-1:0]    completer_id;
    logic [BEAT_W-1:0]      tx_data;
    logic                   tx_sof;
    logic                   tx_eof;
    logic                   tx_valid;
    logic                   tx_ready;
    logic                   irq;

    ready_mode_t            ready_mode;
    chan_model_t            model [NUM_CHANNELS];
    cpl_entry_t             exp_q [NUM_CHANNELS][$];    // Expected completions per channel
    logic [TAG_W-1:0]       next_tag;
    int                     cpl_count;
    int                     error_count;

    dma_hub_top #(
        .NUM_CHANNELS   (NUM_CHANNELS),
        .BAR_INDEX      (BAR_INDEX),
        .CPL_DEPTH      (CPL_DEPTH)
    ) dma_hub_top_i (
        .pcie_clk       (pcie_clk),
        .reset          (reset),
        .rx_data        (rx_data),
        .rx_sof         (rx_sof),
        .rx_eof         (rx_eof),
        .rx_valid       (rx_valid),
        .completer_id   (completer_id),
        .tx_data        (tx_data),
        .tx_sof         (tx_sof),
        .tx_eof         (tx_eof),
        .tx_valid       (tx_valid),
        .tx_ready       (tx_ready),
        .irq            (irq)
    );

    initial begin
        pcie_clk = 1'b0;
        forever #(CLK_PERIOD / 2) pcie_clk = ~pcie_clk;
    end

    // -------------------------------------------------
    // Reference model
    // -------------------------------------------------
    function automatic logic [DATA_W-1:0] model_read(input chan_model_t m,
                                                     input logic [REG_SEL_W-1:0] reg_sel);
        case (reg_sel)
            REG_SCRATCH:  return m.scratch;
            REG_CONTROL:  return {{(DATA_W-1){1'b0}}, m.irq_en};
            REG_DOORBELL: return m.doorbell;
            default:      return {{(DATA_W-2){1'b0}}, m.overflow, m.pending};
        endcase
    endfunction

    function automatic logic any_pending();
        logic any;
        any = 1'b0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            any = any | model[i].pending;
        end
        return any;
    endfunction

    function automatic int outstanding();
        int total;
        total = 0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            total = total + exp_q[i].size();
        end
        return total;
    endfunction

    task automatic update_model(input tlp_op_t op, input int ch,
                                input logic [REG_SEL_W-1:0] reg_sel,
                                input logic [DATA_W-1:0] data, input logic [TAG_W-1:0] tag);
        cpl_entry_t entry;
        if (op == OP_MEM_WR) begin
            case (reg_sel)
                REG_SCRATCH:  model[ch].scratch = data;
                REG_CONTROL:  model[ch].irq_en = data[0];
                REG_DOORBELL: begin
                    model[ch].doorbell = model[ch].doorbell + 32'd1;
                    if (model[ch].irq_en) begin
                        model[ch].pending = 1'b1;
                    end
                end
                default: begin
                    if (data[0]) begin
                        model[ch].pending = 1'b0;
                    end
                    if (data[1]) begin
                        model[ch].overflow = 1'b0;
                    end
                end
            endcase
        end else if (op == OP_MEM_RD) begin
            if (exp_q[ch].size() >= CPL_DEPTH) begin
                model[ch].overflow = 1'b1;              // Read lost on a full queue
            end else begin
                entry.tag  = tag;
                entry.data = model_read(model[ch], reg_sel);
                exp_q[ch].push_back(entry);
            end
        end
    endtask

    // -------------------------------------------------
    // Error handling and compare tasks
    // -------------------------------------------------
    task automatic abort_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_cpl(input cpl_hdr_t hdr, input logic [DATA_W-1:0] data);
        cpl_entry_t exp;
        int         ch;
        ch = int'(hdr.chan);
        if (hdr.op != OP_CPL || hdr.completer_id != COMPLETER_ID || hdr.pad != '0) begin
            abort_run($sformatf("Mismatch at %0t: bad completion header %h", $time, hdr));
        end else if (ch >= NUM_CHANNELS) begin
            abort_run($sformatf("Completion names channel %0d, which does not exist", ch));
        end else if (exp_q[ch].size() == 0) begin
            abort_run($sformatf("Unexpected completion on channel %0d, tag %h", ch, hdr.tag));
        end else begin
            exp = exp_q[ch].pop_front();
            if (hdr.tag != exp.tag || data != exp.data) begin
                abort_run($sformatf(
                    "Mismatch at %0t: channel %0d got tag %h data %h, expected %h %h",
                    $time, ch, hdr.tag, data, exp.tag, exp.data));
            end
            cpl_count++;
        end
    endtask

    task automatic check_irq(input logic exp);
        if (irq !== exp) begin
            abort_run($sformatf("Mismatch at %0t: irq is %b, expected %b", $time, irq, exp));
        end
    endtask

    // -------------------------------------------------
    // Drivers and monitor
    // -------------------------------------------------
    task automatic issue(input tlp_op_t op, input logic [BAR_W-1:0] bar, input int ch,
                         input logic [REG_SEL_W-1:0] reg_sel, input logic [DATA_W-1:0] data);
        req_hdr_t  hdr;
        req_body_t body;
        hdr          = '0;
        hdr.op       = op;
        hdr.bar      = bar;
        hdr.tag      = next_tag;
        body         = '0;
        body.chan    = CHAN_W'(ch);
        body.reg_sel = reg_sel;
        body.data    = data;
        if (bar == BAR_W'(BAR_INDEX) && ch < NUM_CHANNELS) begin
            update_model(op, ch, reg_sel, data, next_tag);
        end
        next_tag = next_tag + 8'd1;
        @(posedge pcie_clk);
        #1;
        rx_valid = 1'b1;                                // Header beat
        rx_sof   = 1'b1;
        rx_data  = hdr;
        @(posedge pcie_clk);
        #1;
        rx_sof   = 1'b0;                                // Body beat
        rx_eof   = 1'b1;
        rx_data  = body;
        @(posedge pcie_clk);
        #1;
        rx_valid = 1'b0;
        rx_eof   = 1'b0;
        rx_data  = '0;
    endtask

    task automatic wait_drained();
        while (outstanding() != 0) begin
            @(posedge pcie_clk);
        end
        #1;
    endtask

    task automatic settle_irq();
        repeat (IRQ_LATENCY) @(posedge pcie_clk);
        #1;
        check_irq(any_pending());
    endtask

    // Beats are sampled mid-cycle while strobes and ready are stable
    initial begin : monitor
        cpl_hdr_t hdr;
        logic     have_hdr;
        hdr      = '0;
        have_hdr = 1'b0;
        forever begin
            @(negedge pcie_clk);
            if (tx_valid === 1'b1 && tx_ready === 1'b1) begin
                if (tx_sof) begin
                    hdr      = cpl_hdr_t'(tx_data);
                    have_hdr = 1'b1;
                end else if (!have_hdr) begin
                    abort_run("Outbound data beat arrived without a header beat");
                end else if (tx_eof !== 1'b1) begin
                    abort_run("Outbound data beat arrived without tx_eof");
                end else if (tx_data[BEAT_W-1:DATA_W] != '0) begin
                    abort_run($sformatf("Mismatch at %0t: data beat upper bits %h",
                                        $time, tx_data));
                end else begin
                    check_cpl(hdr, tx_data[DATA_W-1:0]);
                    have_hdr = 1'b0;
                end
            end
        end
    end

    initial begin : ready_driver
        tx_ready = 1'b1;
        forever begin
            @(posedge pcie_clk);
            #1;
            case (ready_mode)
                READY_RANDOM: tx_ready = ($urandom % 3) != 0;
                READY_LOW:    tx_ready = 1'b0;
                default:      tx_ready = 1'b1;
            endcase
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge pcie_clk);
        abort_run("Timeout, the run did not finish within the expected number of cycles");
    end

    // -------------------------------------------------
    // Tests
    // -------------------------------------------------
    task automatic scratch_roundtrip();
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            issue(OP_MEM_WR, BAR_W'(BAR_INDEX), ch, REG_SCRATCH, $urandom);
        end
        for (int ch = 0; ch < NUM_CHANNELS; ch++) begin
            issue(OP_MEM_RD, BAR_W'(BAR_INDEX), ch, REG_SCRATCH, '0);
        end
        wait_drained();
    endtask

    task automatic filter_requests();
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 0, REG_SCRATCH, 32'h1234_5678);
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX + 1), 0, REG_SCRATCH, 32'hdead_0001);  // Wrong BAR
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), NUM_CHANNELS, REG_SCRATCH, 32'hdead_0002);
        issue(OP_CPL, BAR_W'(BAR_INDEX), 0, REG_SCRATCH, 32'hdead_0003);     // Not a request
        issue(OP_MEM_RD, BAR_W'(BAR_INDEX + 1), 0, REG_SCRATCH, '0);
        issue(OP_MEM_RD, BAR_W'(BAR_INDEX), 0, REG_SCRATCH, '0);
        wait_drained();
    endtask

    task automatic irq_sequence();
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 0, REG_CONTROL, 32'h0);
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 0, REG_DOORBELL, 32'h0);
        settle_irq();
        issue(OP_MEM_RD, BAR_W'(BAR_INDEX), 0, REG_DOORBELL, '0);
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 0, REG_CONTROL, 32'h1);
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 0, REG_DOORBELL, 32'h0);
        settle_irq();
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 1, REG_CONTROL, 32'h1);
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 1, REG_DOORBELL, 32'h0);
        settle_irq();
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 0, REG_STATUS, 32'h1);   // Channel 1 still rings
        settle_irq();
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 1, REG_STATUS, 32'h1);
        settle_irq();
        issue(OP_MEM_RD, BAR_W'(BAR_INDEX), 0, REG_STATUS, '0);
        issue(OP_MEM_RD, BAR_W'(BAR_INDEX), 0, REG_DOORBELL, '0);
        wait_drained();
    endtask

    task automatic random_reads();
        int ch;
        ready_mode = READY_RANDOM;
        for (int n = 0; n < RAND_READS; n++) begin
            ch = int'($urandom % NUM_CHANNELS);
            while (exp_q[ch].size() >= CPL_DEPTH) begin
                @(posedge pcie_clk);                    // Keep the queue from overflowing
            end
            issue(OP_MEM_RD, BAR_W'(BAR_INDEX), ch, REG_SEL_W'($urandom), '0);
        end
        ready_mode = READY_HIGH;
        wait_drained();
    endtask

    task automatic queue_overflow();
        int start_count;
        ready_mode = READY_LOW;
        start_count = cpl_count;
        for (int n = 0; n < CPL_DEPTH + 2; n++) begin
            issue(OP_MEM_RD, BAR_W'(BAR_INDEX), 2, REG_SCRATCH, '0);
        end
        repeat (4) @(posedge pcie_clk);                 // Last read reaches its queue
        ready_mode = READY_HIGH;
        wait_drained();
        if (cpl_count - start_count != CPL_DEPTH) begin
            abort_run($sformatf("Mismatch at %0t: %0d completions after overflow, expected %0d",
                                $time, cpl_count - start_count, CPL_DEPTH));
        end
        issue(OP_MEM_RD, BAR_W'(BAR_INDEX), 2, REG_STATUS, '0);
        issue(OP_MEM_WR, BAR_W'(BAR_INDEX), 2, REG_STATUS, 32'h2);
        issue(OP_MEM_RD, BAR_W'(BAR_INDEX), 2, REG_STATUS, '0);
        wait_drained();
    endtask

    initial begin : main_seq
        void'($urandom(32'h60cf_5d1f));
        rx_data      = '0;
        rx_sof       = 1'b0;
        rx_eof       = 1'b0;
        rx_valid     = 1'b0;
        completer_id = COMPLETER_ID;
        reset        = 1'b1;
        ready_mode   = READY_HIGH;
        next_tag     = 8'h10;
        cpl_count    = 0;
        error_count  = 0;
        for (int i = 0; i < NUM_CHANNELS; i++) begin
            model[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge pcie_clk);
        #1;
        reset = 1'b0;
        check_irq(1'b0);
        if (tx_valid !== 1'b0) begin
            abort_run("tx_valid is not low after reset");
        end
        scratch_roundtrip();
        filter_requests();
        irq_sequence();
        random_reads();
        queue_overflow();
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
hdl/dma_hub_pkg.sv
hdl/rx_request_decoder.sv
hdl/bar_register_channel.sv
hdl/host_return_path.sv
hdl/dma_hub_top.sv
verification/dma_hub_sva.sv
verification/dma_hub_tb.sv

//--- Makefile
VERILATOR  ?= verilator
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing --assert
TOP        ?= dma_hub_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
PASS_MSG   := PASS: all tests

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
